//--- lsu_top.f
verilog/lsu_pkg.sv
verilog/dcache_ctr.sv
verilog/dcache_mem.sv
verilog/load_align.sv
verilog/lsu_top.sv
sim/lsu_assert.sv
sim/lsu_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the lsu testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module lsu_tb -f lsu_top.f -o lsu_sim

status=0
./obj_dir/lsu_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qxF "=== PASS ===" sim.log; then
    echo "result: pass"
else
    echo "result: fail"
    exit 1
fi

//--- sim/lsu_assert.sv
`timescale 1ns/1ps

module lsu_assert
    import lsu_pkg::*;
(
    input logic        clk,
    input logic        rst_n,
    input logic [31:0] ctr_reg_exe0_1,
    input logic        resp_valid,
    input logic        resp_is_load,
    input logic [31:0] load_data
);

    logic req;
    logic ld_req;
    logic sc_req;

    assign req    = (ctr_reg_exe0_1[ctr_type_msb:ctr_type_lsb] == op_class_mem)
                    || (ctr_reg_exe0_1[ctr_type_msb:ctr_type_lsb] == op_class_atomic);
    assign ld_req = ((ctr_reg_exe0_1[ctr_type_msb:ctr_type_lsb] == op_class_mem)
                     && (ctr_reg_exe0_1[ctr_sub_msb:ctr_sub_lsb]
                         inside {sub_ld_b, sub_ld_h, sub_ld_w, sub_ld_bu, sub_ld_hu}))
                    || ((ctr_reg_exe0_1[ctr_type_msb:ctr_type_lsb] == op_class_atomic)
                        && (ctr_reg_exe0_1[ctr_sub_msb:ctr_sub_lsb] == sub_ll));
    assign sc_req = (ctr_reg_exe0_1[ctr_type_msb:ctr_type_lsb] == op_class_atomic)
                    && (ctr_reg_exe0_1[ctr_sub_msb:ctr_sub_lsb] == sub_sc);

    resp_after_req: assert property (@(posedge clk) disable iff (!rst_n) req |=> resp_valid)
        else $error("resp_valid missing one cycle after a request");

    no_resp_after_idle: assert property (@(posedge clk) disable iff (!rst_n)
                                         !req |=> !resp_valid)
        else $error("resp_valid without a request in the cycle before");

    quiet_in_reset: assert property (@(posedge clk) !rst_n |=> !resp_valid)
        else $error("resp_valid high during reset");

    load_has_valid: assert property (@(posedge clk) resp_is_load |-> resp_valid)
        else $error("resp_is_load without resp_valid");

    // stores and cache ops return zero
    no_data_on_store: assert property (@(posedge clk) disable iff (!rst_n)
                                       (req && !ld_req && !sc_req) |=> load_data == 32'b0)
        else $error("load_data not zero on a store or cacop response");

endmodule

bind lsu_top lsu_assert u_assert (
    .clk            (clk),
    .rst_n          (rst_n),
    .ctr_reg_exe0_1 (ctr_reg_exe0_1),
    .resp_valid     (resp_valid),
    .resp_is_load   (resp_is_load),
    .load_data      (load_data)
);

//--- sim/lsu_tb.sv
`timescale 1ns/1ps

module lsu_tb
    import lsu_pkg::*;
();

    localparam int reset_cycles = 10;
    // word 40, byte/half 18, extension 2 x 20, ll/sc 6, cacop 4
    localparam int n_requests = 40 + 18 + 40 + 6 + 4;
    localparam int max_cycles = 2 * n_requests + reset_cycles + 60;

    logic        clk;
    logic        rst_n;
    logic [31:0] rrj1_forward;
    logic [31:0] imm_reg_exe0_1;
    logic [31:0] ctr_reg_exe0_1;
    logic [31:0] rrd1_forward;
    logic [15:0] excp_arg_reg_exe0_1_excp;
    logic        resp_valid;
    logic        resp_is_load;
    logic [31:0] load_data;

    logic [31:0] shadow [dmem_words];   // expected memory contents
    logic        shadow_ll;
    logic [33:0] req_exp;    // {valid, is_load, data} of the request on the inputs
    logic [33:0] resp_exp;   // same, one cycle later
    integer      seed;
    int          cyc;
    int          err_cnt;
    int          chk_cnt;
    int          test_cnt;
    int          fail_cnt;
    int          err_at_start;
    string       cur_test;
    logic [3:0]  key;

    lsu_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc      <= cyc + 1;
        resp_exp <= req_exp;   // one cycle of latency
    end

    initial begin
        while (cyc < max_cycles)
            @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", max_cycles);
        $display("=== FAIL ===");
        $finish;
    end

    always @(negedge clk) begin
        if (rst_n) begin
            if (resp_valid !== resp_exp[33]) begin
                err_cnt++;
                if (resp_exp[33])
                    $display("no response at time %0t in %s after a request", $time, cur_test);
                else
                    $display("response at time %0t in %s without a request", $time, cur_test);
            end else if (resp_exp[33]) begin
                check_value(load_data, resp_exp[31:0], "load_data");
                check_value({31'b0, resp_is_load}, {31'b0, resp_exp[32]}, "resp_is_load");
            end
        end
    end

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("Fail at time %0t: %s, %s is %h, expected %h", $time, cur_test, what, got, exp);
        end
    endtask

    function automatic logic [31:0] rand_word();
        rand_word = $random(seed);
    endfunction

    function automatic logic [31:0] word_addr(input int n);
        word_addr = {22'b0, n[3:0], key ^ n[3:0], 2'b00};   // distinct per n
    endfunction

    // expected load_data of a request, from the shadow state before it
    function automatic logic [31:0] expected_data(input logic [3:0] cls, input logic [4:0] sub,
                                                  input logic [31:0] addr);
        logic [31:0] word;
        logic [7:0]  b;
        logic [15:0] h;
        word = shadow[addr[9:2]];
        b    = word[{addr[1:0], 3'b000} +: 8];
        h    = word[{addr[1], 4'b0000} +: 16];
        expected_data = 32'b0;
        if (cls == op_class_mem && sub == sub_ld_b)
            expected_data = {{24{b[7]}}, b};
        else if (cls == op_class_mem && sub == sub_ld_bu)
            expected_data = {24'b0, b};
        else if (cls == op_class_mem && sub == sub_ld_h && !addr[0])
            expected_data = {{16{h[15]}}, h};
        else if (cls == op_class_mem && sub == sub_ld_hu && !addr[0])
            expected_data = {16'b0, h};
        else if ((cls == op_class_mem && sub == sub_ld_w)
                 || (cls == op_class_atomic && sub == sub_ll))
            expected_data = word;
        else if (cls == op_class_atomic && sub == sub_sc)
            expected_data = {31'b0, shadow_ll};
    endfunction

    task automatic send_request(input logic [3:0] cls, input logic [4:0] sub,
                                input logic [31:0] addr, input logic [31:0] wdata);
        logic [31:0] base;
        logic [31:0] ctr;
        logic [31:0] arg;
        logic        is_ld;
        logic [7:0]  idx;
        logic [1:0]  lo;
        base  = rand_word();
        arg   = rand_word();
        idx   = addr[9:2];
        lo    = addr[1:0];
        is_ld = (cls == op_class_mem
                 && sub inside {sub_ld_b, sub_ld_h, sub_ld_w, sub_ld_bu, sub_ld_hu})
                || (cls == op_class_atomic && sub == sub_ll);
        ctr = 32'b0;
        ctr[ctr_type_msb:ctr_type_lsb] = cls;
        ctr[ctr_sub_msb:ctr_sub_lsb]   = sub;
        // cacop goes out with the write bit set too
        ctr[ctr_rw_bit] = (cls == op_class_mem
                           && sub inside {sub_st_b, sub_st_h, sub_st_w, sub_cacop})
                          || (cls == op_class_atomic && sub == sub_sc);
        @(posedge clk);
        rrj1_forward             <= base;
        imm_reg_exe0_1           <= addr - base;   // base + offset lands on addr
        ctr_reg_exe0_1           <= ctr;
        rrd1_forward             <= wdata;
        excp_arg_reg_exe0_1_excp <= arg[15:0];
        req_exp                  <= {1'b1, is_ld, expected_data(cls, sub, addr)};
        if (cls == op_class_mem && sub == sub_st_w)
            shadow[idx] = wdata;
        else if (cls == op_class_mem && sub == sub_st_b)
            shadow[idx][{lo, 3'b000} +: 8] = wdata[7:0];
        else if (cls == op_class_mem && sub == sub_st_h && !lo[0])
            shadow[idx][{lo[1], 4'b0000} +: 16] = wdata[15:0];
        else if (cls == op_class_atomic && sub == sub_sc) begin
            if (shadow_ll)
                shadow[idx] = wdata;
            shadow_ll = 1'b0;   // any sc drops the reservation
        end else if (cls == op_class_atomic && sub == sub_ll)
            shadow_ll = 1'b1;
    endtask

    // cycle with a type field outside both classes
    task automatic drive_other(input logic [3:0] kind);
        logic [31:0] ctr;
        ctr = rand_word();
        ctr[ctr_type_msb:ctr_type_lsb] = kind;
        @(posedge clk);
        ctr_reg_exe0_1 <= ctr;
        rrj1_forward   <= rand_word();
        rrd1_forward   <= rand_word();
        req_exp        <= 34'b0;
    endtask

    task automatic start_test(input string name);
        cur_test     = name;
        err_at_start = err_cnt;
        test_cnt++;
    endtask

    task automatic end_test();
        drive_other(4'd0);   // drains the last response
        drive_other(4'd0);
        if (err_cnt == err_at_start)
            $display("test %s: ok", cur_test);
        else begin
            $display("test %s: %0d errors", cur_test, err_cnt - err_at_start);
            fail_cnt++;
        end
    endtask

    initial begin
        int          i;
        int          lo;
        logic [31:0] a;
        seed                     = 32'h2870_eed2;
        rst_n                    = 1'b0;
        rrj1_forward             = 32'b0;
        imm_reg_exe0_1           = 32'b0;
        ctr_reg_exe0_1           = 32'b0;
        rrd1_forward             = 32'b0;
        excp_arg_reg_exe0_1_excp = 16'b0;
        req_exp                  = 34'b0;
        shadow_ll                = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;

        start_test("word store and load");
        a   = rand_word();
        key = a[3:0];
        for (i = 0; i < 16; i++)
            send_request(op_class_mem, sub_st_w, word_addr(i), rand_word());
        for (i = 0; i < 16; i++)
            send_request(op_class_mem, sub_ld_w, word_addr(i), 32'b0);
        for (i = 0; i < 4; i++) begin
            send_request(op_class_mem, sub_st_w, word_addr(i), rand_word());
            send_request(op_class_mem, sub_ld_w, word_addr(i), 32'b0);   // right behind it
        end
        end_test();

        start_test("byte and halfword lanes");
        a = 32'h0000_0200;
        for (lo = 0; lo < 6; lo++) begin
            send_request(op_class_mem, sub_st_w, a, rand_word());
            if (lo < 4)
                send_request(op_class_mem, sub_st_b, a + lo, rand_word());
            else
                send_request(op_class_mem, sub_st_h, a + 2 * (lo - 4), rand_word());
            send_request(op_class_mem, sub_ld_w, a, 32'b0);
        end
        end_test();

        start_test("load extension");
        a = 32'h0000_0300;
        for (i = 0; i < 2; i++) begin
            // both signs in every byte and halfword lane across the two words
            send_request(op_class_mem, sub_st_w, a, i == 0 ? 32'hf07f_8001 : 32'h7fff_0f80);
            for (lo = 0; lo < 4; lo++) begin
                send_request(op_class_mem, sub_ld_b, a + lo, 32'b0);
                send_request(op_class_mem, sub_ld_bu, a + lo, 32'b0);
                send_request(op_class_mem, sub_ld_h, a + lo, 32'b0);
                send_request(op_class_mem, sub_ld_hu, a + lo, 32'b0);
            end
            send_request(op_class_mem, sub_st_h, a + 1, rand_word());
            send_request(op_class_mem, sub_st_h, a + 3, rand_word());
            send_request(op_class_mem, sub_ld_w, a, 32'b0);
        end
        end_test();

        start_test("ll and sc");
        a = 32'h0000_0340;
        send_request(op_class_mem, sub_st_w, a, rand_word());
        send_request(op_class_atomic, sub_ll, a, 32'b0);
        send_request(op_class_atomic, sub_sc, a, rand_word());
        send_request(op_class_mem, sub_ld_w, a, 32'b0);
        send_request(op_class_atomic, sub_sc, a, rand_word());   // reservation gone
        send_request(op_class_mem, sub_ld_w, a, 32'b0);
        end_test();

        start_test("cacop and other types");
        a = 32'h0000_0380;
        send_request(op_class_mem, sub_st_w, a, rand_word());
        send_request(op_class_mem, sub_cacop, a, rand_word());
        send_request(op_class_mem, sub_ld_w, a, 32'b0);
        for (i = 0; i < 16; i++)
            if (i != 5 && i != 6)
                drive_other(i[3:0]);
        send_request(op_class_mem, sub_ld_w, a, 32'b0);
        end_test();

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 test_cnt, fail_cnt, chk_cnt, err_cnt);
        if (err_cnt == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- verilog/dcache_ctr.sv
`timescale 1ns/1ps

module dcache_ctr
    import lsu_pkg::*;
(
    input  logic [31:0] rrj1_forward,
    input  logic [31:0] imm_reg_exe0_1,
    input  logic [31:0] ctr_reg_exe0_1,
    input  logic [31:0] rrd1_forward,
    input  logic [15:0] excp_arg_reg_exe0_1_excp,
    output logic [31:0] addr_pipeline_dcache,
    output logic [31:0] din_pipeline_dcache,
    output logic        type_pipeline_dcache,    // 0 read, 1 write
    output logic        pipeline_dcache_valid,
    output logic [3:0]  pipeline_dcache_wstrb,
    output logic [31:0] pipeline_dcache_opcode,  // cacop argument
    output logic        pipeline_dcache_opflag   // 1 for cache ops
);

    logic [3:0]  op_class;
    logic [4:0]  subtype;
    logic [1:0]  lo;
    logic [3:0]  byte_strb;    // one-hot lane
    logic [3:0]  half_strb;
    logic [31:0] byte_data;
    logic [31:0] half_data;

    assign op_class = ctr_reg_exe0_1[ctr_type_msb:ctr_type_lsb];
    assign subtype  = ctr_reg_exe0_1[ctr_sub_msb:ctr_sub_lsb];

    assign addr_pipeline_dcache = rrj1_forward + imm_reg_exe0_1;
    assign lo = addr_pipeline_dcache[1:0];

    assign type_pipeline_dcache  = ctr_reg_exe0_1[ctr_rw_bit];
    assign pipeline_dcache_valid = (op_class == op_class_mem) || (op_class == op_class_atomic);

    // little endian lane placement, shared by loads and stores
    always_comb begin
        byte_strb = 4'b0001 << lo;
        byte_data = {24'b0, rrd1_forward[7:0]} << {lo, 3'b000};
        case (lo)
            2'b00: begin
                half_strb = 4'b0011;
                half_data = {16'b0, rrd1_forward[15:0]};
            end
            2'b10: begin
                half_strb = 4'b1100;
                half_data = {rrd1_forward[15:0], 16'b0};
            end
            default: begin
                // odd halfword address, access is dropped
                half_strb = 4'b0000;
                half_data = 32'b0;
            end
        endcase
    end

    always_comb begin
        din_pipeline_dcache    = 32'b0;
        pipeline_dcache_wstrb  = 4'b0000;
        pipeline_dcache_opflag = 1'b0;
        pipeline_dcache_opcode = 32'b0;
        if (op_class == op_class_mem) begin
            case (subtype)
                sub_ld_b, sub_ld_bu: pipeline_dcache_wstrb = byte_strb;
                sub_ld_h, sub_ld_hu: pipeline_dcache_wstrb = half_strb;
                sub_ld_w:            pipeline_dcache_wstrb = 4'b1111;
                sub_st_b: begin
                    pipeline_dcache_wstrb = byte_strb;
                    din_pipeline_dcache   = byte_data;
                end
                sub_st_h: begin
                    pipeline_dcache_wstrb = half_strb;
                    din_pipeline_dcache   = half_data;
                end
                sub_st_w: begin
                    pipeline_dcache_wstrb = 4'b1111;
                    din_pipeline_dcache   = rrd1_forward;
                end
                sub_cacop: begin
                    pipeline_dcache_opflag = 1'b1;
                    pipeline_dcache_opcode = {16'b0, excp_arg_reg_exe0_1_excp};
                end
                default: ;
            endcase
        end else if (op_class == op_class_atomic) begin
            case (subtype)
                sub_ll: pipeline_dcache_wstrb = 4'b1111;
                sub_sc: begin
                    pipeline_dcache_wstrb = 4'b1111;
                    din_pipeline_dcache   = rrd1_forward;
                end
                default: ;
            endcase
        end
    end

endmodule

//--- verilog/dcache_mem.sv
`timescale 1ns/1ps

module dcache_mem
    import lsu_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] addr,
    input  logic [31:0] din,
    input  logic        we_type,
    input  logic        valid,
    input  logic        opflag,
    input  logic [3:0]  wstrb,
    input  logic [31:0] ctr,
    output logic [31:0] rdata,
    output logic        sc_ok
);

    logic [31:0]              mem [dmem_words];
    logic [dmem_idx_bits-1:0] idx;
    logic                     is_atomic;
    logic                     is_ll;
    logic                     is_sc;
    logic                     llbit;   // load-linked reservation
    logic                     wr_en;

    assign idx = addr[dmem_idx_bits+1:2];

    assign is_atomic = valid && (ctr[ctr_type_msb:ctr_type_lsb] == op_class_atomic);
    assign is_ll     = is_atomic && (ctr[ctr_sub_msb:ctr_sub_lsb] == sub_ll);
    assign is_sc     = is_atomic && (ctr[ctr_sub_msb:ctr_sub_lsb] == sub_sc);

    // sc only lands while the reservation holds, cache ops never write
    assign wr_en = valid && we_type && !opflag && (!is_sc || llbit);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < 4; b++) begin
                if (wstrb[b])
                    mem[idx][8*b +: 8] <= din[8*b +: 8];
            end
        end
    end

    // registered read, previous cycle's write already visible
    always_ff @(posedge clk) begin
        if (valid)
            rdata <= mem[idx];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            llbit <= 1'b0;
            sc_ok <= 1'b0;
        end else begin
            if (is_ll)
                llbit <= 1'b1;
            else if (is_sc)
                llbit <= 1'b0;     // every sc drops it
            sc_ok <= is_sc && llbit;  // seen with the response
        end
    end

endmodule

//--- verilog/load_align.sv
`timescale 1ns/1ps

module load_align
    import lsu_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        valid,
    input  logic [31:0] ctr,
    input  logic [1:0]  addr_lo,
    input  logic [3:0]  wstrb,
    input  logic [31:0] rdata,
    input  logic        sc_ok,
    output logic        resp_valid,
    output logic        resp_is_load,
    output logic [31:0] load_data
);

    logic        valid_q;
    logic [3:0]  class_q;
    logic [4:0]  sub_q;
    logic [1:0]  lo_q;
    logic [3:0]  strb_q;
    logic [7:0]  byte_sel;
    logic [15:0] half_sel;
    logic        is_mem;
    logic        is_atomic;

    always_ff @(posedge clk) begin
        if (!rst_n)
            valid_q <= 1'b0;
        else
            valid_q <= valid;
    end

    // request info for the response cycle
    always_ff @(posedge clk) begin
        class_q <= ctr[ctr_type_msb:ctr_type_lsb];
        sub_q   <= ctr[ctr_sub_msb:ctr_sub_lsb];
        lo_q    <= addr_lo;
        strb_q  <= wstrb;
    end

    assign byte_sel = rdata[8*lo_q +: 8];
    assign half_sel = lo_q[1] ? rdata[31:16] : rdata[15:0];

    assign is_mem    = valid_q && (class_q == op_class_mem);
    assign is_atomic = valid_q && (class_q == op_class_atomic);

    assign resp_valid   = valid_q;
    assign resp_is_load = (is_mem && (sub_q inside {sub_ld_b, sub_ld_h, sub_ld_w,
                                                     sub_ld_bu, sub_ld_hu}))
                        || (is_atomic && (sub_q == sub_ll));

    always_comb begin
        load_data = 32'b0;
        if (is_mem && strb_q != 4'b0000) begin   // zero strobe reads as zero
            case (sub_q)
                sub_ld_b:  load_data = {{24{byte_sel[7]}}, byte_sel};
                sub_ld_bu: load_data = {24'b0, byte_sel};
                sub_ld_h:  load_data = {{16{half_sel[15]}}, half_sel};
                sub_ld_hu: load_data = {16'b0, half_sel};
                sub_ld_w:  load_data = rdata;
                default: ;  // stores and cacop
            endcase
        end else if (is_atomic) begin
            if (sub_q == sub_ll)
                load_data = rdata;
            else if (sub_q == sub_sc)
                load_data = {31'b0, sc_ok};
        end
    end

endmodule

//--- verilog/lsu_pkg.sv
package lsu_pkg;

    // control word fields
    localparam int ctr_type_lsb = 0;
    localparam int ctr_type_msb = 3;
    localparam int ctr_rw_bit   = 5;    // 1 for writes
    localparam int ctr_sub_lsb  = 7;
    localparam int ctr_sub_msb  = 11;

    // opcode classes carried in the type field
    localparam logic [3:0] op_class_mem    = 4'd5;  // loads, stores, cacop
    localparam logic [3:0] op_class_atomic = 4'd6;  // ll / sc pair

    // subtypes of op_class_mem
    localparam logic [4:0] sub_ld_b  = 5'd0;
    localparam logic [4:0] sub_ld_h  = 5'd1;
    localparam logic [4:0] sub_ld_w  = 5'd2;
    localparam logic [4:0] sub_st_b  = 5'd3;
    localparam logic [4:0] sub_st_h  = 5'd4;
    localparam logic [4:0] sub_st_w  = 5'd5;
    localparam logic [4:0] sub_ld_bu = 5'd6;
    localparam logic [4:0] sub_ld_hu = 5'd7;
    localparam logic [4:0] sub_cacop = 5'd8;   // completes as a no-op

    // subtypes of op_class_atomic
    localparam logic [4:0] sub_ll = 5'd0;
    localparam logic [4:0] sub_sc = 5'd1;

    // tightly coupled data memory
    localparam int dmem_words    = 256;
    localparam int dmem_idx_bits = 8;       // word index from addr[9:2]

endpackage

//--- verilog/lsu_top.sv
`timescale 1ns/1ps

module lsu_top (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] rrj1_forward,             // base
    input  logic [31:0] imm_reg_exe0_1,           // offset
    input  logic [31:0] ctr_reg_exe0_1,
    input  logic [31:0] rrd1_forward,             // store source
    input  logic [15:0] excp_arg_reg_exe0_1_excp,
    output logic        resp_valid,
    output logic        resp_is_load,
    output logic [31:0] load_data
);

    logic [31:0] addr_pipeline_dcache;
    logic [31:0] din_pipeline_dcache;
    logic        type_pipeline_dcache;
    logic        pipeline_dcache_valid;
    logic [3:0]  pipeline_dcache_wstrb;
    logic        pipeline_dcache_opflag;
    logic [31:0] rdata;
    logic        sc_ok;

    dcache_ctr u_ctr (
        .rrj1_forward             (rrj1_forward),
        .imm_reg_exe0_1           (imm_reg_exe0_1),
        .ctr_reg_exe0_1           (ctr_reg_exe0_1),
        .rrd1_forward             (rrd1_forward),
        .excp_arg_reg_exe0_1_excp (excp_arg_reg_exe0_1_excp),
        .addr_pipeline_dcache     (addr_pipeline_dcache),
        .din_pipeline_dcache      (din_pipeline_dcache),
        .type_pipeline_dcache     (type_pipeline_dcache),
        .pipeline_dcache_valid    (pipeline_dcache_valid),
        .pipeline_dcache_wstrb    (pipeline_dcache_wstrb),
        .pipeline_dcache_opcode   (),    // no tag array takes the cacop argument
        .pipeline_dcache_opflag   (pipeline_dcache_opflag)
    );

    dcache_mem u_mem (
        .clk     (clk),
        .rst_n   (rst_n),
        .addr    (addr_pipeline_dcache),
        .din     (din_pipeline_dcache),
        .we_type (type_pipeline_dcache),
        .valid   (pipeline_dcache_valid),
        .opflag  (pipeline_dcache_opflag),
        .wstrb   (pipeline_dcache_wstrb),
        .ctr     (ctr_reg_exe0_1),
        .rdata   (rdata),
        .sc_ok   (sc_ok)
    );

    load_align u_align (
        .clk          (clk),
        .rst_n        (rst_n),
        .valid        (pipeline_dcache_valid),
        .ctr          (ctr_reg_exe0_1),
        .addr_lo      (addr_pipeline_dcache[1:0]),
        .wstrb        (pipeline_dcache_wstrb),
        .rdata        (rdata),
        .sc_ok        (sc_ok),
        .resp_valid   (resp_valid),
        .resp_is_load (resp_is_load),
        .load_data    (load_data)
    );

endmodule
